//--- Bender.yml
package:
  name: frontend

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/frontend_pkg.sv
      - rtl/fetch_unit.sv
      - rtl/pair_buffer.sv
      - rtl/decode_lane.sv
      - rtl/inst_queue.sv
      - rtl/frontend_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_frontend.sv

//--- list.f
+incdir+rtl
rtl/frontend_pkg.sv
rtl/fetch_unit.sv
rtl/pair_buffer.sv
rtl/decode_lane.sv
rtl/inst_queue.sv
rtl/frontend_top.sv
tb/tb_frontend.sv

//--- rtl/decode_lane.sv
`timescale 1ns/1ps

module decode_lane (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic [31:0]           in_pc,
    input  logic [31:0]           in_inst,
    output logic                  dec_valid,
    output logic [31:0]           dec_pc,
    output logic [31:0]           dec_inst,
    output frontend_pkg::opcode_t dec_op,
    output logic [4:0]            dec_rd,
    output logic [4:0]            dec_rs1,
    output logic [4:0]            dec_rs2,
    output logic [2:0]            dec_funct3,
    output logic [31:0]           dec_imm
);

    frontend_pkg::major_t  major;
    frontend_pkg::opcode_t op;
    logic [31:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;

    assign major = frontend_pkg::major_t'(in_inst[6:0]);

    // Instruction class from the major opcode
    always_comb begin
        case (major)
            frontend_pkg::MAJ_LUI:    op = frontend_pkg::OP_LUI;
            frontend_pkg::MAJ_AUIPC:  op = frontend_pkg::OP_AUIPC;
            frontend_pkg::MAJ_JAL:    op = frontend_pkg::OP_JAL;
            frontend_pkg::MAJ_JALR:   op = frontend_pkg::OP_JALR;
            frontend_pkg::MAJ_BRANCH: op = frontend_pkg::OP_BRANCH;
            frontend_pkg::MAJ_LOAD:   op = frontend_pkg::OP_LOAD;
            frontend_pkg::MAJ_STORE:  op = frontend_pkg::OP_STORE;
            frontend_pkg::MAJ_IMM:    op = frontend_pkg::OP_IMM;
            frontend_pkg::MAJ_REG:    op = frontend_pkg::OP_REG;
            frontend_pkg::MAJ_FENCE:  op = frontend_pkg::OP_FENCE;
            frontend_pkg::MAJ_SYSTEM: op = frontend_pkg::OP_SYSTEM;
            default:                  op = frontend_pkg::OP_ILLEGAL;
        endcase
    end

    // Immediate format per class
    // Register ops and illegal words carry zero
    always_comb begin
        unique case (op)
            frontend_pkg::OP_LUI, frontend_pkg::OP_AUIPC:
                imm = {in_inst[31:12], 12'b0};
            frontend_pkg::OP_JAL:
                imm = {{11{in_inst[31]}}, in_inst[31], in_inst[19:12], in_inst[20],
                       in_inst[30:21], 1'b0};
            frontend_pkg::OP_BRANCH:
                imm = {{19{in_inst[31]}}, in_inst[31], in_inst[7], in_inst[30:25],
                       in_inst[11:8], 1'b0};
            frontend_pkg::OP_STORE:
                imm = {{20{in_inst[31]}}, in_inst[31:25], in_inst[11:7]};
            frontend_pkg::OP_JALR, frontend_pkg::OP_LOAD, frontend_pkg::OP_IMM,
            frontend_pkg::OP_FENCE, frontend_pkg::OP_SYSTEM:
                imm = {{20{in_inst[31]}}, in_inst[31:20]};
            default:
                imm = 32'b0;
        endcase
    end

    // No destination for branch, store and fence
    assign rd = (op == frontend_pkg::OP_BRANCH || op == frontend_pkg::OP_STORE ||
                 op == frontend_pkg::OP_FENCE) ? 5'd0 : in_inst[11:7];
    // U and J formats have no rs1 field
    assign rs1 = (op == frontend_pkg::OP_LUI || op == frontend_pkg::OP_AUIPC ||
                  op == frontend_pkg::OP_JAL) ? 5'd0 : in_inst[19:15];
    // rs2 only for branch, store and register ops
    assign rs2 = (op == frontend_pkg::OP_BRANCH || op == frontend_pkg::OP_STORE ||
                  op == frontend_pkg::OP_REG) ? in_inst[24:20] : 5'd0;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // Fields captured with the pair, one cycle after pair_valid
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec_pc     <= in_pc;
            dec_inst   <= in_inst;
            dec_op     <= op;
            dec_rd     <= rd;
            dec_rs1    <= rs1;
            dec_rs2    <= rs2;
            dec_funct3 <= in_inst[14:12];
            dec_imm    <= imm;
        end
    end

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module fetch_unit (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] imem_addr,
    output logic [3:0]  imem_rmask,
    input  logic [31:0] imem_rdata,
    input  logic        imem_resp,
    input  logic        pair_ready,
    output logic        fetch_valid,
    output logic [31:0] fetch_pc,
    output logic [31:0] fetch_inst
);

    frontend_pkg::fetch_state_t state;
    frontend_pkg::fetch_state_t state_next;
    logic [31:0] pc;
    logic        resp_hit;

    // Response only counts while a request is open
    assign resp_hit = (state == frontend_pkg::FS_WAIT) && imem_resp;

    always_comb begin
        state_next = state;
        unique case (state)
            frontend_pkg::FS_IDLE: begin
                state_next = pair_ready ? frontend_pkg::FS_WAIT : frontend_pkg::FS_HOLD;
            end
            frontend_pkg::FS_WAIT: begin
                // Back to back request if the buffer still has room
                if (imem_resp) begin
                    state_next = pair_ready ? frontend_pkg::FS_WAIT : frontend_pkg::FS_HOLD;
                end
            end
            frontend_pkg::FS_HOLD: begin
                if (pair_ready) begin
                    state_next = frontend_pkg::FS_WAIT;
                end
            end
            default: state_next = frontend_pkg::FS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= frontend_pkg::FS_IDLE;
            pc    <= `FE_RESET_PC;
        end else begin
            state <= state_next;
            // Next sequential word once this one is delivered
            if (resp_hit) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // Address and mask stay steady until the response
    assign imem_addr  = pc;
    assign imem_rmask = (state == frontend_pkg::FS_WAIT) ? 4'hf : 4'h0;

    // Word goes straight to the pair buffer in the response cycle
    assign fetch_valid = resp_hit;
    assign fetch_pc    = pc;
    assign fetch_inst  = imem_rdata;

endmodule

//--- rtl/frontend_macros.svh
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// First fetch address out of reset
`define FE_RESET_PC 32'h6000_0000

// Queue entries
// Kept even since a push always writes two
`define FE_QUEUE_DEPTH 8

// Credit counter width
// Must hold FE_QUEUE_DEPTH itself
`define FE_CREDIT_W 4

// One queue entry
// funct3 3, imm 32, rs2 5, rs1 5, rd 5, op 4, inst 32, pc 32
`define FE_ENTRY_W 118

`endif

//--- rtl/frontend_pkg.sv
package frontend_pkg;

    // Decoded instruction class
    // Travels with every queue entry toward issue
    typedef enum logic [3:0] {
        OP_LUI     = 4'd0,
        OP_AUIPC   = 4'd1,
        OP_JAL     = 4'd2,
        OP_JALR    = 4'd3,
        OP_BRANCH  = 4'd4,
        OP_LOAD    = 4'd5,
        OP_STORE   = 4'd6,
        OP_IMM     = 4'd7,
        OP_REG     = 4'd8,
        OP_FENCE   = 4'd9,
        OP_SYSTEM  = 4'd10,
        // Any major opcode outside RV32I
        OP_ILLEGAL = 4'd11
    } opcode_t;

    // Fetch FSM states
    typedef enum logic [1:0] {
        // Leaving reset, nothing requested yet
        FS_IDLE = 2'd0,
        // Request open on the instruction port
        FS_WAIT = 2'd1,
        // Pair buffer cannot take another word
        FS_HOLD = 2'd2
    } fetch_state_t;

    // RV32I major opcodes in inst[6:0]
    typedef enum logic [6:0] {
        MAJ_LUI    = 7'b0110111,
        MAJ_AUIPC  = 7'b0010111,
        MAJ_JAL    = 7'b1101111,
        MAJ_JALR   = 7'b1100111,
        MAJ_BRANCH = 7'b1100011,
        MAJ_LOAD   = 7'b0000011,
        MAJ_STORE  = 7'b0100011,
        MAJ_IMM    = 7'b0010011,
        MAJ_REG    = 7'b0110011,
        MAJ_FENCE  = 7'b0001111,
        MAJ_SYSTEM = 7'b1110011
    } major_t;

endpackage

//--- rtl/frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
    input  logic                  clk,
    input  logic                  rst,
    output logic [31:0]           imem_addr,
    output logic [3:0]            imem_rmask,
    input  logic [31:0]           imem_rdata,
    input  logic                  imem_resp,
    input  logic                  out_pop,
    output logic                  out_valid,
    output logic [31:0]           out_pc,
    output logic [31:0]           out_inst,
    output frontend_pkg::opcode_t out_op,
    output logic [4:0]            out_rd,
    output logic [4:0]            out_rs1,
    output logic [4:0]            out_rs2,
    output logic [2:0]            out_funct3,
    output logic [31:0]           out_imm
);

    logic                  fetch_valid;
    logic [31:0]           fetch_pc;
    logic [31:0]           fetch_inst;
    logic                  pair_ready;
    logic                  pair_valid;
    logic [31:0]           pair_pc [2];
    logic [31:0]           pair_inst [2];
    logic                  credit_ret;
    // Lanes run in lockstep, lane 0 valid stands for both
    logic                  dec_valid [2];
    logic [31:0]           dec_pc [2];
    logic [31:0]           dec_inst [2];
    frontend_pkg::opcode_t dec_op [2];
    logic [4:0]            dec_rd [2];
    logic [4:0]            dec_rs1 [2];
    logic [4:0]            dec_rs2 [2];
    logic [2:0]            dec_funct3 [2];
    logic [31:0]           dec_imm [2];

    fetch_unit fetch_unit_i (
        .clk(clk), .rst(rst),
        .imem_addr(imem_addr), .imem_rmask(imem_rmask),
        .imem_rdata(imem_rdata), .imem_resp(imem_resp),
        .pair_ready(pair_ready), .fetch_valid(fetch_valid),
        .fetch_pc(fetch_pc), .fetch_inst(fetch_inst)
    );

    pair_buffer pair_buffer_i (
        .clk(clk), .rst(rst),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_inst(fetch_inst),
        .credit_ret(credit_ret), .pair_ready(pair_ready), .pair_valid(pair_valid),
        .pair_pc(pair_pc), .pair_inst(pair_inst)
    );

    // One lane per pair slot
    for (genvar g = 0; g < 2; g++) begin : g_lane
        decode_lane decode_lane_i (
            .clk(clk), .rst(rst),
            .in_valid(pair_valid), .in_pc(pair_pc[g]), .in_inst(pair_inst[g]),
            .dec_valid(dec_valid[g]), .dec_pc(dec_pc[g]), .dec_inst(dec_inst[g]),
            .dec_op(dec_op[g]), .dec_rd(dec_rd[g]), .dec_rs1(dec_rs1[g]),
            .dec_rs2(dec_rs2[g]), .dec_funct3(dec_funct3[g]), .dec_imm(dec_imm[g])
        );
    end

    inst_queue inst_queue_i (
        .clk(clk), .rst(rst), .push(dec_valid[0]),
        .in_pc(dec_pc), .in_inst(dec_inst), .in_op(dec_op), .in_rd(dec_rd),
        .in_rs1(dec_rs1), .in_rs2(dec_rs2), .in_funct3(dec_funct3), .in_imm(dec_imm),
        .out_pop(out_pop), .out_valid(out_valid), .out_pc(out_pc), .out_inst(out_inst),
        .out_op(out_op), .out_rd(out_rd), .out_rs1(out_rs1), .out_rs2(out_rs2),
        .out_funct3(out_funct3), .out_imm(out_imm), .credit_ret(credit_ret)
    );

endmodule

//--- rtl/inst_queue.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module inst_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  logic [31:0]           in_pc [2],
    input  logic [31:0]           in_inst [2],
    input  frontend_pkg::opcode_t in_op [2],
    input  logic [4:0]            in_rd [2],
    input  logic [4:0]            in_rs1 [2],
    input  logic [4:0]            in_rs2 [2],
    input  logic [2:0]            in_funct3 [2],
    input  logic [31:0]           in_imm [2],
    input  logic                  out_pop,
    output logic                  out_valid,
    output logic [31:0]           out_pc,
    output logic [31:0]           out_inst,
    output frontend_pkg::opcode_t out_op,
    output logic [4:0]            out_rd,
    output logic [4:0]            out_rs1,
    output logic [4:0]            out_rs2,
    output logic [2:0]            out_funct3,
    output logic [31:0]           out_imm,
    output logic                  credit_ret
);

    localparam int PTR_W = $clog2(`FE_QUEUE_DEPTH);

    logic [`FE_ENTRY_W-1:0]  mem [`FE_QUEUE_DEPTH];
    logic [`FE_ENTRY_W-1:0]  entry_in [2];
    logic [`FE_ENTRY_W-1:0]  head_entry;
    logic [PTR_W-1:0]        head;
    logic [PTR_W-1:0]        tail;
    logic [PTR_W-1:0]        tail_second;
    logic [PTR_W-1:0]        tail_next;
    logic [`FE_CREDIT_W-1:0] count;
    logic [`FE_CREDIT_W-1:0] count_next;
    logic                    pop_ok;

    // Wrapping increment, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`FE_QUEUE_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign tail_second = ptr_inc(tail);
    assign tail_next   = ptr_inc(tail_second);
    assign out_valid   = (count != '0);
    assign pop_ok      = out_pop && out_valid;

    // Pack each lane, lane 0 is the older instruction
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            entry_in[i] = {in_funct3[i], in_imm[i], in_rs2[i], in_rs1[i], in_rd[i],
                           in_op[i], in_inst[i], in_pc[i]};
        end
    end

    always_comb begin
        count_next = count;
        if (push) begin
            count_next = count_next + `FE_CREDIT_W'(2);
        end
        if (pop_ok) begin
            count_next = count_next - `FE_CREDIT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            count      <= count_next;
            // Freed entry goes back to the pair buffer next cycle
            credit_ret <= pop_ok;
            if (push) begin
                tail <= tail_next;
            end
            if (pop_ok) begin
                head <= ptr_inc(head);
            end
        end
    end

    // Space was reserved by credits, no full check here
    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail]        <= entry_in[0];
            mem[tail_second] <= entry_in[1];
        end
    end

    assign head_entry = mem[head];
    assign {out_funct3, out_imm, out_rs2, out_rs1, out_rd} = head_entry[`FE_ENTRY_W-1:68];
    assign out_op   = frontend_pkg::opcode_t'(head_entry[67:64]);
    assign out_inst = head_entry[63:32];
    assign out_pc   = head_entry[31:0];

endmodule

//--- rtl/pair_buffer.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module pair_buffer (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_valid,
    input  logic [31:0] fetch_pc,
    input  logic [31:0] fetch_inst,
    input  logic        credit_ret,
    output logic        pair_ready,
    output logic        pair_valid,
    output logic [31:0] pair_pc [2],
    output logic [31:0] pair_inst [2]
);

    // Occupied slots, 0 to 2
    logic [1:0] occ;
    logic [1:0] occ_base;
    logic [1:0] occ_next;
    logic [`FE_CREDIT_W-1:0] credits;
    logic [`FE_CREDIT_W-1:0] credits_next;

    // Full pair leaves only with two queue entries reserved
    assign pair_valid = (occ == 2'd2) && (credits >= `FE_CREDIT_W'(2));

    // Slot count seen by an arriving word
    assign occ_base = pair_valid ? 2'd0 : occ;
    assign occ_next = occ_base + {1'b0, fetch_valid};

    // A new request needs a free slot for its word
    // A full pair that is sure to leave next cycle frees slot 0 in time
    assign pair_ready = (occ_next < 2'd2) || (credits_next >= `FE_CREDIT_W'(2));

    always_comb begin
        credits_next = credits;
        if (pair_valid) begin
            credits_next = credits_next - `FE_CREDIT_W'(2);
        end
        // One entry freed per pop in the queue
        if (credit_ret) begin
            credits_next = credits_next + `FE_CREDIT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            occ     <= 2'd0;
            credits <= `FE_CREDIT_W'(`FE_QUEUE_DEPTH);
        end else begin
            occ     <= occ_next;
            credits <= credits_next;
        end
    end

    // Slot 0 takes the older word, slot 1 the younger
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            pair_pc[occ_base[0]]   <= fetch_pc;
            pair_inst[occ_base[0]] <= fetch_inst;
        end
    end

endmodule

//--- tb/tb_frontend.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module tb_frontend;

    localparam int TOTAL_INST   = 2000;
    localparam int CYC_PER_INST = 40;
    localparam int TPUT_WINDOW  = 300;
    // Consumer modes
    localparam int CONS_RANDOM  = 0;
    localparam int CONS_STOP    = 1;
    localparam int CONS_ALL     = 2;

    logic                  clk = 1'b0;
    logic                  rst;
    logic [31:0]           imem_addr;
    logic [3:0]            imem_rmask;
    logic [31:0]           imem_rdata;
    logic                  imem_resp;
    logic                  out_pop;
    logic                  out_valid;
    logic [31:0]           out_pc;
    logic [31:0]           out_inst;
    frontend_pkg::opcode_t out_op;
    logic [4:0]            out_rd;
    logic [4:0]            out_rs1;
    logic [4:0]            out_rs2;
    logic [2:0]            out_funct3;
    logic [31:0]           out_imm;

    // Values of the cycle that ends at the next rising edge
    logic [3:0]  s_rmask;
    logic [31:0] s_addr;
    logic        s_out_valid;
    // Monitor and model state
    int unsigned seed_dummy;
    int unsigned cyc = 0;
    int unsigned fetched = 0;
    int unsigned popped = 0;
    int          cons_mode;
    int          lat_left;
    int          phase_left = 0;
    bit          busy = 1'b0;
    bit          stream_mem;
    bit          was_rst = 1'b0;
    bit          req_open;
    bit          took;
    logic [31:0] req_addr;
    logic [31:0] exp_fetch;
    logic [31:0] exp_pc;
    logic [31:0] exp_inst;
    logic [31:0] r_imm;
    logic [4:0]  r_rd;
    logic [4:0]  r_rs1;
    logic [4:0]  r_rs2;
    frontend_pkg::opcode_t r_op;

    frontend_top frontend_top_i (
        .clk(clk), .rst(rst),
        .imem_addr(imem_addr), .imem_rmask(imem_rmask),
        .imem_rdata(imem_rdata), .imem_resp(imem_resp),
        .out_pop(out_pop), .out_valid(out_valid), .out_pc(out_pc), .out_inst(out_inst),
        .out_op(out_op), .out_rd(out_rd), .out_rs1(out_rs1), .out_rs2(out_rs2),
        .out_funct3(out_funct3), .out_imm(out_imm)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] pc,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else
            stop_with_error($sformatf("MISMATCH at %0t ns: %s at pc %h is %h, expected %h",
                                      $time, name, pc, got, exp));
    endtask

    // Major opcode table, 11 RV32I classes and 5 codes outside the ISA
    function automatic logic [6:0] major_pick(input logic [3:0] idx);
        logic [6:0] tbl [16];
        tbl = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h13,
                7'h33, 7'h0f, 7'h73, 7'h00, 7'h7f, 7'h2b, 7'h5b, 7'h0b};
        return tbl[idx];
    endfunction

    // Program word as a fixed hash of the full address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        h = addr * 32'h9e37_79b1;
        h = h ^ (h >> 15) ^ {addr[15:0], addr[31:16]};
        return {h[31:7], major_pick(h[3:0])};
    endfunction

    // Expected decode of one word from the RV32I formats
    function automatic void ref_decode(input logic [31:0] w,
                                       output frontend_pkg::opcode_t op,
                                       output logic [4:0] rd, output logic [4:0] rs1,
                                       output logic [4:0] rs2, output logic [31:0] imm);
        logic [20:0] j_raw;
        logic [12:0] b_raw;
        logic [11:0] s_raw;
        logic [11:0] i_raw;
        j_raw = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        b_raw = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        s_raw = {w[31:25], w[11:7]};
        i_raw = w[31:20];
        imm = 32'($signed(i_raw));
        case (w[6:0])
            7'h37: begin op = frontend_pkg::OP_LUI;    imm = {w[31:12], 12'h000}; end
            7'h17: begin op = frontend_pkg::OP_AUIPC;  imm = {w[31:12], 12'h000}; end
            7'h6f: begin op = frontend_pkg::OP_JAL;    imm = 32'($signed(j_raw)); end
            7'h63: begin op = frontend_pkg::OP_BRANCH; imm = 32'($signed(b_raw)); end
            7'h23: begin op = frontend_pkg::OP_STORE;  imm = 32'($signed(s_raw)); end
            7'h67: op = frontend_pkg::OP_JALR;
            7'h03: op = frontend_pkg::OP_LOAD;
            7'h13: op = frontend_pkg::OP_IMM;
            7'h0f: op = frontend_pkg::OP_FENCE;
            7'h73: op = frontend_pkg::OP_SYSTEM;
            7'h33: begin op = frontend_pkg::OP_REG;     imm = 32'h0; end
            default: begin op = frontend_pkg::OP_ILLEGAL; imm = 32'h0; end
        endcase
        // Fields the class does not use read as zero
        rd  = (op inside {frontend_pkg::OP_BRANCH, frontend_pkg::OP_STORE,
                          frontend_pkg::OP_FENCE}) ? 5'd0 : w[11:7];
        rs1 = (op inside {frontend_pkg::OP_LUI, frontend_pkg::OP_AUIPC,
                          frontend_pkg::OP_JAL}) ? 5'd0 : w[19:15];
        rs2 = (op inside {frontend_pkg::OP_BRANCH, frontend_pkg::OP_STORE,
                          frontend_pkg::OP_REG}) ? w[24:20] : 5'd0;
    endfunction

    // Instruction memory
    // Random latency of 0 to 4 cycles, or a word every cycle in streaming mode
    always @(posedge clk) begin
        if (rst) begin
            imem_resp  <= 1'b0;
            imem_rdata <= 32'h0;
            lat_left   = -1;
        end else begin
            took = imem_resp && (s_rmask != 4'h0);
            if (stream_mem) begin
                // PC only moves on an accepted word
                imem_resp  <= 1'b1;
                imem_rdata <= mem_word(took ? s_addr + 32'd4 : s_addr);
                lat_left   = -1;
            end else if (imem_resp) begin
                imem_resp <= 1'b0;
                lat_left  = -1;
            end else if (s_rmask != 4'h0) begin
                if (lat_left < 0) begin
                    lat_left = $urandom_range(4, 0);
                end
                if (lat_left == 0) begin
                    imem_resp  <= 1'b1;
                    imem_rdata <= mem_word(s_addr);
                    lat_left   = -1;
                end else begin
                    lat_left--;
                end
            end
        end
    end

    // Consumer with busy and idle phases
    // The queue ignores a pop while it is empty
    always @(posedge clk) begin
        if (rst) begin
            out_pop <= 1'b0;
        end else if (cons_mode == CONS_ALL) begin
            out_pop <= 1'b1;
        end else if (cons_mode == CONS_STOP) begin
            out_pop <= 1'b0;
        end else begin
            if (phase_left == 0) begin
                busy       = !busy;
                phase_left = $urandom_range(12, 1);
            end else begin
                phase_left--;
            end
            out_pop <= busy && s_out_valid && ($urandom_range(3, 0) != 0);
        end
    end

    // Monitors sample in the middle of the cycle
    always @(negedge clk) begin
        s_rmask     = imem_rmask;
        s_addr      = imem_addr;
        s_out_valid = out_valid;
        if (rst) begin
            req_open  = 1'b0;
            exp_fetch = `FE_RESET_PC;
            exp_pc    = `FE_RESET_PC;
            if (cyc > 0) begin
                assert (imem_rmask == 4'h0 && !out_valid) else
                    stop_with_error("Request or output valid raised during reset");
            end
        end else begin
            if (was_rst) begin
                assert (imem_rmask == 4'h0 && !out_valid) else
                    stop_with_error("Request or output valid raised right after reset");
            end
            // Fetch order and a steady address until the response
            if (imem_rmask != 4'h0) begin
                check_field("imem_rmask", imem_addr, 32'(imem_rmask), 32'hf);
                if (!req_open) begin
                    check_field("request address", imem_addr, imem_addr, exp_fetch);
                    req_open = 1'b1;
                    req_addr = imem_addr;
                end else begin
                    check_field("held address", req_addr, imem_addr, req_addr);
                end
                if (imem_resp) begin
                    req_open  = 1'b0;
                    exp_fetch = exp_fetch + 32'd4;
                    fetched++;
                end
            end else begin
                assert (!req_open) else
                    stop_with_error("Fetch dropped a request before its response");
            end
            // Credits bound the words held between memory and consumer
            assert (fetched - popped <= `FE_QUEUE_DEPTH + 2) else
                stop_with_error($sformatf("MISMATCH at %0t ns: %0d words held, limit %0d",
                                          $time, fetched - popped, `FE_QUEUE_DEPTH + 2));
            if (out_valid && out_pop) begin
                exp_inst = mem_word(exp_pc);
                ref_decode(exp_inst, r_op, r_rd, r_rs1, r_rs2, r_imm);
                check_field("out_pc", exp_pc, out_pc, exp_pc);
                check_field("out_inst", exp_pc, out_inst, exp_inst);
                check_field("out_op", exp_pc, 32'(out_op), 32'(r_op));
                check_field("out_rd", exp_pc, 32'(out_rd), 32'(r_rd));
                check_field("out_rs1", exp_pc, 32'(out_rs1), 32'(r_rs1));
                check_field("out_rs2", exp_pc, 32'(out_rs2), 32'(r_rs2));
                check_field("out_funct3", exp_pc, 32'(out_funct3), 32'(exp_inst[14:12]));
                check_field("out_imm", exp_pc, out_imm, r_imm);
                exp_pc = exp_pc + 32'd4;
                popped++;
            end
        end
        was_rst = rst;
    end

    task automatic wait_for_pops(input int unsigned n);
        while (popped < n) begin
            @(posedge clk);
        end
    endtask

    initial begin
        seed_dummy = $urandom(32'he46b9c36);
        rst        = 1'b1;
        imem_rdata = 32'h0;
        imem_resp  = 1'b0;
        out_pop    = 1'b0;
        cons_mode  = CONS_RANDOM;
        stream_mem = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        wait_for_pops(800);
        // Stall the consumer until credits run out
        @(negedge clk);
        cons_mode = CONS_STOP;
        repeat (120) @(posedge clk);
        assert (s_rmask == 4'h0) else
            stop_with_error("Fetch kept requesting while the queue was full");
        assert (fetched - popped >= `FE_QUEUE_DEPTH + 1) else
            stop_with_error($sformatf("MISMATCH at %0t ns: only %0d words held at stall",
                                      $time, fetched - popped));
        @(negedge clk);
        cons_mode = CONS_RANDOM;
        wait_for_pops(1400);
        // Zero latency memory and a pop every cycle
        @(negedge clk);
        stream_mem = 1'b1;
        cons_mode  = CONS_ALL;
        @(posedge clk);
        while (!s_out_valid) begin
            @(posedge clk);
        end
        // Let the pipeline settle into streaming
        repeat (20) @(posedge clk);
        // Overlapped pairs keep the queue from running dry
        for (int i = 0; i < TPUT_WINDOW; i++) begin
            @(posedge clk);
            assert (s_out_valid) else
                stop_with_error($sformatf("MISMATCH at %0t ns: out_valid fell while streaming",
                                          $time));
        end
        @(negedge clk);
        stream_mem = 1'b0;
        cons_mode  = CONS_RANDOM;
        wait_for_pops(TOTAL_INST);
        @(negedge clk);
        cons_mode = CONS_STOP;
        repeat (5) @(posedge clk);
        $display("Finished with no errors");
        $finish;
    end

    // Watchdog sized from the instruction count
    initial begin
        repeat (TOTAL_INST * CYC_PER_INST) @(posedge clk);
        $display("Timeout: %0d of %0d instructions popped in %0d cycles",
                 popped, TOTAL_INST, TOTAL_INST * CYC_PER_INST);
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

endmodule
